// ==== scr1_memif_pkg.sv ====
package scr1_memif_pkg;

	// --------------------
	// dmem bus
	// --------------------
	localparam int DMEM_AWIDTH = 32;
	localparam int DMEM_DWIDTH = 32;

	typedef enum logic {
		SCR1_MEM_CMD_RD = 1'b0,
		SCR1_MEM_CMD_WR = 1'b1
	} mem_cmd_e;

	typedef enum logic [1:0] {
		SCR1_MEM_WIDTH_BYTE  = 2'b00,
		SCR1_MEM_WIDTH_HWORD = 2'b01,
		SCR1_MEM_WIDTH_WORD  = 2'b10
	} mem_width_e;

	// only ready-ok is ever returned, no error response
	typedef enum logic [1:0] {
		SCR1_MEM_RESP_NOTRDY = 2'b00,
		SCR1_MEM_RESP_RDY_OK = 2'b01
	} mem_resp_e;

	// --------------------
	// register map
	// --------------------
	// word index comes from addr[8:2]
	typedef logic [6:0] word_idx_t;

	localparam word_idx_t IDX_CTRL       = 7'd0;
	localparam word_idx_t IDX_COUNTER    = 7'd1;
	localparam word_idx_t IDX_DATA_A     = 7'd2;
	localparam word_idx_t IDX_DATA_B     = 7'd3;
	localparam word_idx_t IDX_DATA_C     = 7'd4;
	// 16 message words
	localparam word_idx_t IDX_MSG_BASE   = 7'd13;
	// 64 schedule words, read only
	localparam word_idx_t IDX_SCHED_BASE = 7'd29;

	// data word, whole or per byte lane
	typedef union packed {
		logic [DMEM_DWIDTH-1:0]        word;
		logic [DMEM_DWIDTH/8-1:0][7:0] lane;
	} mem_word_u;

endpackage

// ==== sha256_pkg.sv ====
package sha256_pkg;

	// --------------------
	// schedule sizes
	// --------------------
	localparam int MSG_WORDS   = 16;
	localparam int SCHED_WORDS = 64;

	typedef logic [31:0] sched_word_t;
	typedef logic [5:0]  sched_idx_t;
	typedef logic [4:0]  step_t;

	// steps needed to expand words 16..63
	function automatic int last_step(int words_per_step);
		return (SCHED_WORDS - MSG_WORDS) / words_per_step;
	endfunction

	// --------------------
	// small sigma
	// --------------------
	function automatic sched_word_t rotr(sched_word_t x, int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// applied to w[i-15]
	function automatic sched_word_t sig0(sched_word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	// applied to w[i-2]
	function automatic sched_word_t sig1(sched_word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

endpackage

// ==== reg_bus_if.sv ====
interface reg_bus_if import scr1_memif_pkg::*; ();

	// single-cycle strobes, valid in the dmem request cycle
	logic      wr;
	logic      rd;
	word_idx_t idx;
	// already replicated for narrow writes
	mem_word_u wdata;
	// read word, combinational on idx
	mem_word_u rdata;

	modport slave (
		output wr, rd, idx, wdata,
		input  rdata
	);

	modport regfile (
		input  wr, rd, idx, wdata,
		output rdata
	);

endinterface

// ==== accel_bus_slave.sv ====
module accel_bus_slave import scr1_memif_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic                   dmem_req_ack,
	input  logic                   dmem_req,
	input  mem_cmd_e               dmem_cmd,
	input  mem_width_e             dmem_width,
	input  logic [DMEM_AWIDTH-1:0] dmem_addr,
	input  logic [DMEM_DWIDTH-1:0] dmem_wdata,
	output logic [DMEM_DWIDTH-1:0] dmem_rdata,
	output mem_resp_e              dmem_resp,
	reg_bus_if.slave               bus
);

	mem_word_u rdata_q;
	logic [1:0] offs_q;

	// --------------------
	// request side
	// --------------------
	// never back-pressure the core
	assign dmem_req_ack = 1'b1;

	assign bus.wr  = dmem_req && (dmem_cmd == SCR1_MEM_CMD_WR);
	assign bus.rd  = dmem_req && (dmem_cmd == SCR1_MEM_CMD_RD);
	assign bus.idx = dmem_addr[8:2];

	// narrow writes land in every lane
	always_comb begin
		bus.wdata.word = dmem_wdata;
		case (dmem_width)
			SCR1_MEM_WIDTH_BYTE: begin
				for (int i = 0; i < DMEM_DWIDTH / 8; i++) begin
					bus.wdata.lane[i] = dmem_wdata[7:0];
				end
			end
			SCR1_MEM_WIDTH_HWORD: begin
				bus.wdata.word = {(DMEM_DWIDTH / 16){dmem_wdata[15:0]}};
			end
			default: begin
			end
		endcase
	end

	// --------------------
	// response side
	// --------------------
	// ready-ok exactly one cycle after each request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dmem_resp <= SCR1_MEM_RESP_NOTRDY;
		end else begin
			dmem_resp <= dmem_req ? SCR1_MEM_RESP_RDY_OK : SCR1_MEM_RESP_NOTRDY;
		end
	end

	// word and byte offset sampled at the request edge
	always_ff @(posedge clk) begin
		if (bus.rd) begin
			rdata_q <= bus.rdata;
			offs_q  <= dmem_addr[1:0];
		end
	end

	// shift down by 8 x offset
	assign dmem_rdata = rdata_q.word >> {offs_q, 3'b000};

	// response must trace back to a request in the previous cycle
	a_resp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_resp == SCR1_MEM_RESP_RDY_OK) |-> $past(dmem_req));

endmodule

// ==== accel_regfile.sv ====
module accel_regfile
	import scr1_memif_pkg::*;
	import sha256_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	reg_bus_if.regfile  bus,
	output logic        go,
	input  step_t       step,
	input  logic        done,
	output mem_word_u   data_a,
	output mem_word_u   data_b,
	input  mem_word_u   data_c,
	output sched_word_t msg [MSG_WORDS],
	output sched_idx_t  sched_idx,
	input  sched_word_t sched_word
);

	localparam int MSG_IW = $clog2(MSG_WORDS);

	word_idx_t msg_off;
	word_idx_t sched_off;
	logic      is_msg;
	logic      is_sched;
	logic      ctrl_wr;
	mem_word_u rd_word;

	// --------------------
	// address decode
	// --------------------
	// offsets wrap below the base, so one compare covers each window
	assign msg_off   = bus.idx - IDX_MSG_BASE;
	assign sched_off = bus.idx - IDX_SCHED_BASE;
	assign is_msg    = msg_off < word_idx_t'(MSG_WORDS);
	assign is_sched  = sched_off < word_idx_t'(SCHED_WORDS);
	assign sched_idx = sched_off[$bits(sched_idx_t)-1:0];

	// any value written to ctrl starts both engines
	assign ctrl_wr = bus.wr && (bus.idx == IDX_CTRL);

	// --------------------
	// control and operands
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			go     <= 1'b0;
			data_a <= '0;
			data_b <= '0;
		end else begin
			go <= ctrl_wr;
			if (bus.wr && (bus.idx == IDX_DATA_A)) begin
				data_a <= bus.wdata;
			end
			if (bus.wr && (bus.idx == IDX_DATA_B)) begin
				data_b <= bus.wdata;
			end
		end
	end

	// message block, taken by the schedule at step 0
	always_ff @(posedge clk) begin
		if (bus.wr && is_msg) begin
			msg[msg_off[MSG_IW-1:0]] <= bus.wdata.word;
		end
	end

	// --------------------
	// read mux
	// --------------------
	always_comb begin
		rd_word.word = '0;
		if (is_msg) begin
			rd_word.word = msg[msg_off[MSG_IW-1:0]];
		end else if (is_sched) begin
			rd_word.word = sched_word;
		end else begin
			case (bus.idx)
				IDX_CTRL:    rd_word.word = {done, {(DMEM_DWIDTH-2){1'b0}}, go};
				IDX_COUNTER: rd_word.word = DMEM_DWIDTH'(step);
				IDX_DATA_A:  rd_word = data_a;
				IDX_DATA_B:  rd_word = data_b;
				IDX_DATA_C:  rd_word = data_c;
				// unmapped reads as zero
				default: begin
				end
			endcase
		end
	end

	// slave samples this on a read strobe
	assign bus.rdata = rd_word;

	// back-to-back ctrl writes would stretch the pulse
	a_go_pulse: assert property (@(posedge clk) disable iff (!rst_n) go |=> !go);

endmodule

// ==== accel_sequencer.sv ====
module accel_sequencer import sha256_pkg::*; #(
	parameter int WORDS_PER_STEP = 2
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  go,
	output step_t step,
	output logic  done
);

	localparam step_t LAST_STEP = step_t'(last_step(WORDS_PER_STEP));
	localparam step_t IDLE_STEP = LAST_STEP + step_t'(1);

	step_t cnt_q;
	logic  busy_q;
	logic  done_q;

	// step 0 is the go cycle itself
	assign step = go ? '0 : cnt_q;
	// a new go hides the old done at once
	assign done = done_q && !go;

	// --------------------
	// counter and done
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q  <= IDLE_STEP;
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else if (go) begin
			// restart, also mid-run
			cnt_q  <= step_t'(1);
			busy_q <= 1'b1;
			done_q <= 1'b0;
		end else begin
			// count up, then rest at idle
			if (cnt_q != IDLE_STEP) begin
				cnt_q <= cnt_q + step_t'(1);
			end
			// done one cycle after reaching idle
			if (busy_q && (cnt_q == IDLE_STEP)) begin
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	a_step_range: assert property (@(posedge clk) disable iff (!rst_n)
		step <= IDLE_STEP);

endmodule

// ==== byte_mul_engine.sv ====
module byte_mul_engine
	import scr1_memif_pkg::*;
	import sha256_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  step_t     step,
	input  mem_word_u data_a,
	input  mem_word_u data_b,
	output mem_word_u data_c
);

	logic [1:0] lane;
	logic       active;
	logic [7:0] prod;

	// --------------------
	// lane select
	// --------------------
	// steps 0..3 map to lanes 0..3
	assign lane   = step[1:0];
	assign active = (step[4:2] == 3'b000);

	// only the low byte of the product is kept
	assign prod = data_a.lane[lane] * data_b.lane[lane];

	// --------------------
	// result word
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_c <= '0;
		end else if (active) begin
			// other lanes keep their value
			data_c.lane[lane] <= prod;
		end
	end

endmodule

// ==== msg_schedule.sv ====
module msg_schedule import sha256_pkg::*; #(
	parameter int WORDS_PER_STEP = 2
) (
	input  logic        clk,
	input  logic        rst_n,
	input  step_t       step,
	input  sched_word_t msg [MSG_WORDS],
	input  sched_idx_t  sched_idx,
	output sched_word_t sched_word
);

	localparam step_t LAST_STEP = step_t'(last_step(WORDS_PER_STEP));

	sched_word_t w   [SCHED_WORDS];
	sched_word_t nxt [WORDS_PER_STEP];
	logic        expand;
	int          base;

	// core is little-endian, schedule wants big-endian
	function automatic sched_word_t bswap(sched_word_t x);
		return {x[7:0], x[15:8], x[23:16], x[31:24]};
	endfunction

	// --------------------
	// expansion
	// --------------------
	assign expand = (step != '0) && (step <= LAST_STEP);

	// new words never feed each other within one step while WORDS_PER_STEP <= 2
	always_comb begin
		base = MSG_WORDS;
		if (expand) begin
			base = MSG_WORDS + WORDS_PER_STEP * (int'(step) - 1);
		end
		for (int k = 0; k < WORDS_PER_STEP; k++) begin
			nxt[k] = sig1(w[base + k - 2]) + w[base + k - 7]
				+ sig0(w[base + k - 15]) + w[base + k - 16];
		end
	end

	// --------------------
	// storage
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SCHED_WORDS; i++) begin
				w[i] <= '0;
			end
		end else if (step == '0) begin
			// load words 0..15
			for (int i = 0; i < MSG_WORDS; i++) begin
				w[i] <= bswap(msg[i]);
			end
		end else if (expand) begin
			for (int k = 0; k < WORDS_PER_STEP; k++) begin
				w[base + k] <= nxt[k];
			end
		end
	end

	// read port for the register map
	assign sched_word = w[sched_idx];

endmodule

// ==== scr1_accel.sv ====
module scr1_accel
	import scr1_memif_pkg::*;
	import sha256_pkg::*;
#(
	parameter int WORDS_PER_STEP = 2
) (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic                   dmem_req_ack,
	input  logic                   dmem_req,
	input  mem_cmd_e               dmem_cmd,
	input  mem_width_e             dmem_width,
	input  logic [DMEM_AWIDTH-1:0] dmem_addr,
	input  logic [DMEM_DWIDTH-1:0] dmem_wdata,
	output logic [DMEM_DWIDTH-1:0] dmem_rdata,
	output mem_resp_e              dmem_resp
);

	logic        go;
	logic        done;
	step_t       step;
	mem_word_u   data_a;
	mem_word_u   data_b;
	mem_word_u   data_c;
	sched_word_t msg [MSG_WORDS];
	sched_idx_t  sched_idx;
	sched_word_t sched_word;

	reg_bus_if bus_if ();

	// --------------------
	// bus and registers
	// --------------------
	accel_bus_slave accel_bus_slave_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.dmem_req_ack (dmem_req_ack),
		.dmem_req     (dmem_req),
		.dmem_cmd     (dmem_cmd),
		.dmem_width   (dmem_width),
		.dmem_addr    (dmem_addr),
		.dmem_wdata   (dmem_wdata),
		.dmem_rdata   (dmem_rdata),
		.dmem_resp    (dmem_resp),
		.bus          (bus_if.slave)
	);

	accel_regfile accel_regfile_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.bus        (bus_if.regfile),
		.go         (go),
		.step       (step),
		.done       (done),
		.data_a     (data_a),
		.data_b     (data_b),
		.data_c     (data_c),
		.msg        (msg),
		.sched_idx  (sched_idx),
		.sched_word (sched_word)
	);

	// --------------------
	// engines
	// --------------------
	accel_sequencer #(
		.WORDS_PER_STEP (WORDS_PER_STEP)
	) accel_sequencer_i (
		.clk   (clk),
		.rst_n (rst_n),
		.go    (go),
		.step  (step),
		.done  (done)
	);

	byte_mul_engine byte_mul_engine_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.step   (step),
		.data_a (data_a),
		.data_b (data_b),
		.data_c (data_c)
	);

	msg_schedule #(
		.WORDS_PER_STEP (WORDS_PER_STEP)
	) msg_schedule_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.step       (step),
		.msg        (msg),
		.sched_idx  (sched_idx),
		.sched_word (sched_word)
	);

endmodule

// ==== tb_scr1_accel.sv ====
module tb_scr1_accel
	import scr1_memif_pkg::*;
	import sha256_pkg::*;
();

	localparam int WORDS_PER_STEP = 2;
	// 48 new words, idle one past the last step
	localparam int IDLE_STEP = (SCHED_WORDS - MSG_WORDS) / WORDS_PER_STEP + 1;
	localparam int N_RW = 24;
	localparam int N_UNMAPPED = 8;
	localparam int N_MUL = 4;
	localparam int N_BLOCKS = 3;
	localparam int MAX_POLLS = 40;
	// polls not included, they ride on the per-go allowance
	localparam int N_ACCESS = 5 + SCHED_WORDS + N_RW * 5 + N_UNMAPPED * 2 + 2
		+ N_MUL * 6 + N_BLOCKS * (MSG_WORDS + 3 + SCHED_WORDS);
	// two cycles per access: request, then response
	localparam int TIMEOUT_CYCLES = 2 * (2 * N_ACCESS) + 30 * (N_MUL + N_BLOCKS) + 10;

	logic                   clk;
	logic                   rst_n;
	logic                   dmem_req_ack;
	logic                   dmem_req;
	mem_cmd_e               dmem_cmd;
	mem_width_e             dmem_width;
	logic [DMEM_AWIDTH-1:0] dmem_addr;
	logic [DMEM_DWIDTH-1:0] dmem_wdata;
	logic [DMEM_DWIDTH-1:0] dmem_rdata;
	mem_resp_e              dmem_resp;

	logic [31:0] lfsr;
	int          mismatches;
	int          failures;
	int          cycles;
	mem_word_u   model_a;
	mem_word_u   model_b;
	mem_word_u   model_c;
	sched_word_t model_msg [MSG_WORDS];
	sched_word_t model_w [SCHED_WORDS];

	scr1_accel #(
		.WORDS_PER_STEP (WORDS_PER_STEP)
	) scr1_accel_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.dmem_req_ack (dmem_req_ack),
		.dmem_req     (dmem_req),
		.dmem_cmd     (dmem_cmd),
		.dmem_width   (dmem_width),
		.dmem_addr    (dmem_addr),
		.dmem_wdata   (dmem_wdata),
		.dmem_rdata   (dmem_rdata),
		.dmem_resp    (dmem_resp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// cycle limit
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		$display("Test failed");
		$finish;
	end

	// --------------------
	// random numbers
	// --------------------
	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic mem_width_e rand_width();
		logic [1:0] r;
		r = rand_bits(2);
		case (r)
			2'd0:    return SCR1_MEM_WIDTH_BYTE;
			2'd1:    return SCR1_MEM_WIDTH_HWORD;
			default: return SCR1_MEM_WIDTH_WORD;
		endcase
	endfunction

	// --------------------
	// reference model
	// --------------------
	// narrow writes fill the whole word
	function automatic mem_word_u replicate(mem_width_e width, logic [31:0] d);
		mem_word_u r;
		case (width)
			SCR1_MEM_WIDTH_BYTE:  r.word = {4{d[7:0]}};
			SCR1_MEM_WIDTH_HWORD: r.word = {2{d[15:0]}};
			default:              r.word = d;
		endcase
		return r;
	endfunction

	function automatic sched_word_t rotate_right(sched_word_t x, int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic sched_word_t small_sigma0(sched_word_t x);
		return rotate_right(x, 7) ^ rotate_right(x, 18) ^ (x >> 3);
	endfunction

	function automatic sched_word_t small_sigma1(sched_word_t x);
		return rotate_right(x, 17) ^ rotate_right(x, 19) ^ (x >> 10);
	endfunction

	// little-endian core word to big-endian
	function automatic sched_word_t byte_reverse(sched_word_t x);
		return {x[7:0], x[15:8], x[23:16], x[31:24]};
	endfunction

	function automatic void build_schedule();
		for (int i = 0; i < MSG_WORDS; i++) begin
			model_w[i] = byte_reverse(model_msg[i]);
		end
		for (int i = MSG_WORDS; i < SCHED_WORDS; i++) begin
			model_w[i] = small_sigma1(model_w[i-2]) + model_w[i-7]
				+ small_sigma0(model_w[i-15]) + model_w[i-16];
		end
	endfunction

	// low byte of each lane product
	function automatic void build_products();
		logic [15:0] prod;
		for (int i = 0; i < 4; i++) begin
			prod = 16'(model_a.lane[i]) * 16'(model_b.lane[i]);
			model_c.lane[i] = prod[7:0];
		end
	endfunction

	// --------------------
	// compare tasks
	// --------------------
	task automatic check_word(mem_word_u got, mem_word_u exp, string what);
		if (got.word !== exp.word) begin
			mismatches++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got.word, exp.word);
		end
	endtask

	task automatic check_sched(sched_word_t got, sched_word_t exp, string what);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(mem_resp_e got, mem_resp_e exp, string what);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s got %s expected %s", $time, what,
				got.name(), exp.name());
		end
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// --------------------
	// bus tasks
	// --------------------
	// entered and left 1 unit after a rising edge
	task automatic bus_access(mem_cmd_e cmd, mem_width_e width, logic [31:0] addr,
		logic [31:0] wdata, output logic [31:0] rdata);
		dmem_req   = 1'b1;
		dmem_cmd   = cmd;
		dmem_width = width;
		dmem_addr  = addr;
		dmem_wdata = wdata;
		#1;
		check_flag(dmem_req_ack, 1'b1, "req_ack in request cycle");
		@(posedge clk);
		#1;
		// response cycle
		dmem_req = 1'b0;
		check_resp(dmem_resp, SCR1_MEM_RESP_RDY_OK, "response after request");
		rdata = dmem_rdata;
		@(posedge clk);
		#1;
		check_resp(dmem_resp, SCR1_MEM_RESP_NOTRDY, "response without request");
	endtask

	task automatic write_reg(word_idx_t idx, mem_width_e width, logic [31:0] d);
		logic [31:0] unused;
		bus_access(SCR1_MEM_CMD_WR, width, DMEM_AWIDTH'({idx, 2'b00}), d, unused);
	endtask

	task automatic read_reg(word_idx_t idx, logic [1:0] off, output mem_word_u d);
		mem_width_e  width;
		logic [31:0] r;
		width = (off == 2'd0) ? SCR1_MEM_WIDTH_WORD : SCR1_MEM_WIDTH_BYTE;
		bus_access(SCR1_MEM_CMD_RD, width, DMEM_AWIDTH'({idx, off}), rand_bits(32), r);
		d.word = r;
	endtask

	// go write, then poll done
	task automatic start_and_wait();
		mem_word_u rd;
		mem_word_u exp;
		int        polls;
		write_reg(IDX_CTRL, SCR1_MEM_WIDTH_WORD, rand_bits(32));
		// both engines run off the same go
		build_products();
		build_schedule();
		read_reg(IDX_CTRL, 2'd0, rd);
		exp.word = '0;
		check_word(rd, exp, "ctrl right after go");
		polls = 0;
		while (!rd.word[31] && polls < MAX_POLLS) begin
			read_reg(IDX_CTRL, 2'd0, rd);
			polls++;
		end
		if (!rd.word[31]) begin
			failures++;
			$display("error at %0t: done never rose after go", $time);
		end else begin
			exp.word = 32'h8000_0000;
			check_word(rd, exp, "ctrl when done");
		end
		read_reg(IDX_COUNTER, 2'd0, rd);
		exp.word = IDLE_STEP;
		check_word(rd, exp, "counter at idle");
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		mem_word_u   rd;
		mem_word_u   exp;
		mem_word_u   shifted;
		word_idx_t   idx;
		mem_width_e  width;
		logic [31:0] data;
		lfsr       = 32'h9f5c6e79;
		mismatches = 0;
		failures   = 0;
		model_a    = '0;
		model_b    = '0;
		model_c    = '0;
		rst_n      = 1'b0;
		dmem_req   = 1'b0;
		dmem_cmd   = SCR1_MEM_CMD_RD;
		dmem_width = SCR1_MEM_WIDTH_WORD;
		dmem_addr  = '0;
		dmem_wdata = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_resp(dmem_resp, SCR1_MEM_RESP_NOTRDY, "response after reset");

		// reset values
		exp.word = '0;
		read_reg(IDX_CTRL, 2'd0, rd);
		check_word(rd, exp, "ctrl after reset");
		read_reg(IDX_DATA_A, 2'd0, rd);
		check_word(rd, exp, "data_a after reset");
		read_reg(IDX_DATA_B, 2'd0, rd);
		check_word(rd, exp, "data_b after reset");
		read_reg(IDX_DATA_C, 2'd0, rd);
		check_word(rd, exp, "data_c after reset");
		read_reg(IDX_COUNTER, 2'd0, rd);
		exp.word = IDLE_STEP;
		check_word(rd, exp, "counter after reset");
		for (int i = 0; i < SCHED_WORDS; i++) begin
			read_reg(IDX_SCHED_BASE + word_idx_t'(i), 2'd0, rd);
			check_sched(rd.word, '0, $sformatf("schedule word %0d after reset", i));
		end

		// operand writes, shifted reads
		for (int n = 0; n < N_RW; n++) begin
			width = rand_width();
			data  = rand_bits(32);
			if (rand_bits(1) != 0) begin
				idx     = IDX_DATA_B;
				model_b = replicate(width, data);
				exp     = model_b;
			end else begin
				idx     = IDX_DATA_A;
				model_a = replicate(width, data);
				exp     = model_a;
			end
			write_reg(idx, width, data);
			for (int off = 0; off < 4; off++) begin
				read_reg(idx, 2'(off), rd);
				shifted.word = exp.word >> (8 * off);
				check_word(rd, shifted, $sformatf("operand idx %0d offset %0d", idx, off));
			end
		end

		// unmapped words, below the message window or above the schedule
		exp.word = '0;
		for (int n = 0; n < N_UNMAPPED; n++) begin
			if (rand_bits(1) != 0) begin
				idx = IDX_DATA_C + word_idx_t'(1) + word_idx_t'(rand_bits(3));
			end else begin
				idx = IDX_SCHED_BASE + word_idx_t'(SCHED_WORDS) + word_idx_t'(rand_bits(5));
			end
			write_reg(idx, SCR1_MEM_WIDTH_WORD, rand_bits(32));
			read_reg(idx, 2'd0, rd);
			check_word(rd, exp, $sformatf("unmapped idx %0d", idx));
		end

		// result word is read only
		write_reg(IDX_DATA_C, SCR1_MEM_WIDTH_WORD, rand_bits(32));
		read_reg(IDX_DATA_C, 2'd0, rd);
		check_word(rd, model_c, "data_c after write");

		// byte-lane multiplier
		for (int r = 0; r < N_MUL; r++) begin
			model_a.word = rand_bits(32);
			model_b.word = rand_bits(32);
			write_reg(IDX_DATA_A, SCR1_MEM_WIDTH_WORD, model_a.word);
			write_reg(IDX_DATA_B, SCR1_MEM_WIDTH_WORD, model_b.word);
			start_and_wait();
			read_reg(IDX_DATA_C, 2'd0, rd);
			check_word(rd, model_c, $sformatf("products round %0d", r));
		end

		// message schedule, one block per pass
		for (int b = 0; b < N_BLOCKS; b++) begin
			for (int i = 0; i < MSG_WORDS; i++) begin
				model_msg[i] = rand_bits(32);
				write_reg(IDX_MSG_BASE + word_idx_t'(i), SCR1_MEM_WIDTH_WORD, model_msg[i]);
			end
			start_and_wait();
			for (int i = 0; i < SCHED_WORDS; i++) begin
				read_reg(IDX_SCHED_BASE + word_idx_t'(i), 2'd0, rd);
				check_sched(rd.word, model_w[i], $sformatf("block %0d word %0d", b, i));
			end
		end

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== all.f ====
scr1_memif_pkg.sv
sha256_pkg.sv
reg_bus_if.sv
accel_bus_slave.sv
accel_regfile.sv
accel_sequencer.sv
byte_mul_engine.sv
msg_schedule.sv
scr1_accel.sv
tb_scr1_accel.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_scr1_accel
FILELIST  = all.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
